// ==== run_sim.sh ====
#!/bin/sh
# Build the VDC testbench with Verilator, run it and look for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_vdc -o vtb_vdc
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/vtb_vdc)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation passed"; then
	exit 0
fi
exit 1

// ==== src.f ====
+incdir+src
src/vdc_reg_pkg.sv
src/vdc_timing_pkg.sv
src/vdc_regfile.sv
src/vdc_signals_h.sv
src/vdc_signals_v.sv
src/vdc_signals.sv
src/vdc_top.sv
tb/tb_vdc.sv

// ==== src/vdc_config.svh ====
// ------------------------------------------------
// VDC build constants
// blanking porch and width for both directions
// APB address width and register address map
// ------------------------------------------------

`ifndef VDC_CONFIG_SVH
`define VDC_CONFIG_SVH

`define VDC_HB_FRONT_PORCH 2   // chars from hsync start to hblank start
`define VDC_HB_WIDTH       25  // hblank length in chars
`define VDC_VB_FRONT_PORCH 2   // lines from vsync start to vblank start
`define VDC_VB_WIDTH       34  // vblank length in lines

`define VDC_ADDR_W 8           // APB paddr width

`define VDC_R_HT   8'h00       // R0  horizontal total (minus 1)
`define VDC_R_HD   8'h01       // R1  horizontal displayed
`define VDC_R_HP   8'h02       // R2  hsync position
`define VDC_R_SW   8'h03       // R3  vw[7:4], hw[3:0]
`define VDC_R_VT   8'h04       // R4  vertical total (minus 1)
`define VDC_R_VA   8'h05       // R5  vertical total adjust
`define VDC_R_VD   8'h06       // R6  vertical displayed
`define VDC_R_VP   8'h07       // R7  vsync position (plus 1)
`define VDC_R_CTV  8'h09       // R9  char total vertical (minus 1)
`define VDC_R_CTH  8'h16       // R22 char total horizontal in [7:4]
`define VDC_R_CTRL 8'h28       // R40 bit 0 enables the timing core

`endif

// ==== src/vdc_reg_pkg.sv ====
// ------------------------------------------------
// host side types
// APB request and response structs
// register index enum, timing register set
// ------------------------------------------------

`include "vdc_config.svh"

package vdc_reg_pkg;

	typedef struct packed {
		logic                   psel;     // slave selected
		logic                   penable;  // access phase
		logic                   pwrite;   // 1 = write
		logic [`VDC_ADDR_W-1:0] paddr;
		logic [7:0]             pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [7:0] prdata;
		logic       pready;   // tied high, no wait states
		logic       pslverr;  // tied low
	} apb_rsp_t;

	typedef enum logic [3:0] {
		idx_ht, idx_hd, idx_hp, idx_sw, idx_vt, idx_va,
		idx_vd, idx_vp, idx_ctv, idx_cth, idx_ctrl, idx_none
	} vdc_reg_e;

	typedef struct packed {
		logic [7:0] ht;      // R0
		logic [7:0] hd;      // R1
		logic [7:0] hp;      // R2
		logic [3:0] vw;      // R3[7:4]
		logic [3:0] hw;      // R3[3:0]
		logic [7:0] vt;      // R4
		logic [4:0] va;      // R5
		logic [7:0] vd;      // R6
		logic [7:0] vp;      // R7
		logic [4:0] ctv;     // R9
		logic [3:0] cth;     // R22[7:4]
		logic       enable;  // R40[0]
	} vdc_regs_t;

endpackage

// ==== src/vdc_regfile.sv ====
// ------------------------------------------------
// APB slave for the CRTC timing registers
// zero wait state writes, combinational readback
// R3 holds vw and hw packed into one byte
// ------------------------------------------------

`include "vdc_config.svh"

module vdc_regfile (
	input  logic                   clk,
	input  logic                   reset,
	input  vdc_reg_pkg::apb_req_t  apb_req,
	output vdc_reg_pkg::apb_rsp_t  apb_rsp,
	output vdc_reg_pkg::vdc_regs_t regs
);
	import vdc_reg_pkg::*;

	vdc_reg_e   sel;    // decoded register index
	logic       wr_en;  // write strobe in access phase
	logic [7:0] rdata;

	always_comb begin
		case (apb_req.paddr)
			`VDC_R_HT:   sel = idx_ht;
			`VDC_R_HD:   sel = idx_hd;
			`VDC_R_HP:   sel = idx_hp;
			`VDC_R_SW:   sel = idx_sw;
			`VDC_R_VT:   sel = idx_vt;
			`VDC_R_VA:   sel = idx_va;
			`VDC_R_VD:   sel = idx_vd;
			`VDC_R_VP:   sel = idx_vp;
			`VDC_R_CTV:  sel = idx_ctv;
			`VDC_R_CTH:  sel = idx_cth;
			`VDC_R_CTRL: sel = idx_ctrl;
			default:     sel = idx_none;  // unmapped, reads zero
		endcase
	end

	assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite;

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= '0;  // enable clear, core idle
		end else if (wr_en) begin
			case (sel)
				idx_ht:   regs.ht <= apb_req.pwdata;
				idx_hd:   regs.hd <= apb_req.pwdata;
				idx_hp:   regs.hp <= apb_req.pwdata;
				idx_sw: begin
					regs.vw <= apb_req.pwdata[7:4];
					regs.hw <= apb_req.pwdata[3:0];
				end
				idx_vt:   regs.vt <= apb_req.pwdata;
				idx_va:   regs.va <= apb_req.pwdata[4:0];
				idx_vd:   regs.vd <= apb_req.pwdata;
				idx_vp:   regs.vp <= apb_req.pwdata;
				idx_ctv:  regs.ctv <= apb_req.pwdata[4:0];
				idx_cth:  regs.cth <= apb_req.pwdata[7:4];  // low nibble not kept
				idx_ctrl: regs.enable <= apb_req.pwdata[0];
				default:  ;  // writes to unmapped space dropped
			endcase
		end
	end

	always_comb begin
		case (sel)
			idx_ht:   rdata = regs.ht;
			idx_hd:   rdata = regs.hd;
			idx_hp:   rdata = regs.hp;
			idx_sw:   rdata = {regs.vw, regs.hw};
			idx_vt:   rdata = regs.vt;
			idx_va:   rdata = {3'd0, regs.va};
			idx_vd:   rdata = regs.vd;
			idx_vp:   rdata = regs.vp;
			idx_ctv:  rdata = {3'd0, regs.ctv};
			idx_cth:  rdata = {regs.cth, 4'd0};
			idx_ctrl: rdata = {7'd0, regs.enable};
			default:  rdata = 8'd0;
		endcase
	end

	assign apb_rsp.prdata  = rdata;
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = 1'b0;

	// master must run a setup cycle before every access cycle
	a_apb_setup: assert property (@(posedge clk) disable iff (reset)
		apb_req.penable |-> apb_req.psel && $past(apb_req.psel))
		else $error("APB access phase without psel or setup cycle");

endmodule

// ==== src/vdc_signals.sv ====
// ------------------------------------------------
// display timing core
// horizontal and vertical generators
// line event decode from column events
// cursor/attribute blink divider
// ------------------------------------------------

module vdc_signals (
	input  logic                   clk,
	input  logic                   reset,
	input  vdc_reg_pkg::vdc_regs_t regs,
	output vdc_timing_pkg::video_t video
);
	import vdc_timing_pkg::*;

	col_evt_t   cevt;
	line_evt_t  levt;
	logic [7:0] hsync_col;    // column whose end starts hsync
	logic       hsync;
	logic       hblank;
	logic       hVisible;
	logic       vsync;
	logic       vblank;
	logic       vVisible;
	logic       fetchFrame;
	logic       fetchRow;
	logic       fetchLine;
	logic       updateBlink;  // one pulse per frame
	logic [1:0] blink;
	logic [3:0] bcnt16;       // low bits below blink[0]
	logic [3:0] bcnt15;       // mod 15 for blink[1]

	vdc_signals_h signals_h (
		.clk       (clk),
		.reset     (reset),
		.enable    (regs.enable),
		.regs      (regs),
		.hSyncStart(levt.hSyncStart),
		.cevt      (cevt),
		.hsync     (hsync),
		.hblank    (hblank),
		.hVisible  (hVisible)
	);

	// hp of 0 puts hsync at the very end of the line
	assign hsync_col       = (regs.hp != 8'd0) ? regs.hp - 8'd1 : regs.ht;
	assign levt.lineStart  = cevt.newCol && cevt.col == 8'd0;
	assign levt.hSyncStart = cevt.endCol && cevt.col == hsync_col;
	assign levt.lineEnd    = cevt.endCol && cevt.col == regs.ht;

	vdc_signals_v signals_v (
		.clk        (clk),
		.reset      (reset),
		.enable     (regs.enable),
		.regs       (regs),
		.levt       (levt),
		.vsync      (vsync),
		.vblank     (vblank),
		.vVisible   (vVisible),
		.fetchFrame (fetchFrame),
		.fetchRow   (fetchRow),
		.fetchLine  (fetchLine),
		.updateBlink(updateBlink)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			blink  <= 2'b00;
			bcnt16 <= 4'd0;
			bcnt15 <= 4'd0;
		end else if (updateBlink) begin
			{blink[0], bcnt16} <= {blink[0], bcnt16} + 5'd1;  // carry flips blink[0]
			if (bcnt15 == 4'd14) begin
				bcnt15   <= 4'd0;
				blink[1] <= ~blink[1];
			end else begin
				bcnt15 <= bcnt15 + 4'd1;
			end
		end
	end

	always_comb begin
		video.hsync      = hsync;
		video.vsync      = vsync;
		video.hblank     = hblank;
		video.vblank     = vblank;
		video.hVisible   = hVisible;
		video.vVisible   = vVisible;
		video.fetchFrame = fetchFrame;
		video.fetchRow   = fetchRow;
		video.fetchLine  = fetchLine;
		video.blink      = blink;
	end

endmodule

// ==== src/vdc_signals_h.sv ====
// ------------------------------------------------
// horizontal timing generator
// pixel and column counters, column events
// hsync/hblank sequencer and hVisible flag
// ------------------------------------------------

`include "vdc_config.svh"

module vdc_signals_h (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     enable,
	input  vdc_reg_pkg::vdc_regs_t   regs,
	input  logic                     hSyncStart,
	output vdc_timing_pkg::col_evt_t cevt,
	output logic                     hsync,
	output logic                     hblank,
	output logic                     hVisible
);
	import vdc_timing_pkg::*;

	localparam logic [7:0] hb_on  = 8'(`VDC_HB_FRONT_PORCH);  // hblank rise, chars
	localparam logic [7:0] hb_off = 8'(`VDC_HB_FRONT_PORCH + `VDC_HB_WIDTH);

	logic [3:0]  pixel;     // pixel within the character
	logic [7:0]  col;       // character column
	sync_state_e state;
	logic [7:0]  seq_cnt;   // chars since hsync start
	logic [7:0]  seq_next;

	// column events straight off the counters, dead while disabled
	assign cevt.newCol = enable && pixel == 4'd0;
	assign cevt.endCol = enable && pixel >= regs.cth;
	assign cevt.col    = col;

	assign seq_next = seq_cnt + 8'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			pixel <= 4'd0;
			col   <= 8'd0;
		end else if (enable) begin
			if (pixel >= regs.cth) begin  // character done
				pixel <= 4'd0;
				col   <= (col >= regs.ht) ? 8'd0 : col + 8'd1;  // line wrap
			end else begin
				pixel <= pixel + 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= st_idle;
			seq_cnt <= 8'd0;
			hsync   <= 1'b0;
			hblank  <= 1'b0;
		end else if (enable) begin
			if (hSyncStart) begin  // restarts any running sequence
				state   <= st_sync;
				seq_cnt <= 8'd0;
				hsync   <= regs.hw != 4'd0;
				if (hb_on == 8'd0)
					hblank <= 1'b1;
			end else if (state != st_idle && cevt.endCol) begin
				seq_cnt <= seq_next;
				if (seq_next == hb_on)
					hblank <= 1'b1;
				if (seq_next == hb_off)
					hblank <= 1'b0;
				case (state)
					st_sync: begin
						if (seq_next >= {4'd0, regs.hw}) begin  // hw chars elapsed
							hsync <= 1'b0;
							state <= (seq_next >= hb_off) ? st_idle : st_blank;
						end
					end
					st_blank: begin
						if (seq_next >= hb_off)
							state <= st_idle;
					end
					default: ;
				endcase
			end
		end
	end

	// first hd chars of each line
	always_ff @(posedge clk) begin
		if (reset)
			hVisible <= 1'b0;
		else if (cevt.newCol && col == 8'd0)
			hVisible <= regs.hd != 8'd0;
		else if (cevt.newCol && col == regs.hd)  // first pixel past the displayed chars
			hVisible <= 1'b0;
	end

endmodule

// ==== src/vdc_signals_v.sv ====
// ------------------------------------------------
// vertical timing generator
// scanline, row and adjust counters
// vsync/vblank sequencer, vVisible, fetch strobes
// frame end strobe for the blink divider
// ------------------------------------------------

`include "vdc_config.svh"

module vdc_signals_v (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      enable,
	input  vdc_reg_pkg::vdc_regs_t    regs,
	input  vdc_timing_pkg::line_evt_t levt,
	output logic                      vsync,
	output logic                      vblank,
	output logic                      vVisible,
	output logic                      fetchFrame,
	output logic                      fetchRow,
	output logic                      fetchLine,
	output logic                      updateBlink
);
	import vdc_timing_pkg::*;

	localparam logic [7:0] vb_on  = 8'(`VDC_VB_FRONT_PORCH);  // lines after vsync start
	localparam logic [7:0] vb_off = 8'(`VDC_VB_FRONT_PORCH + `VDC_VB_WIDTH);

	logic [4:0]  line;       // scanline within the row
	logic [7:0]  row;        // character row
	logic [4:0]  adj_cnt;    // lines into the adjust phase
	logic        in_adj;     // past the last row, adding va lines
	logic        last_line;
	logic        last_row;
	logic        adj_done;
	logic        frame_end;
	logic        disp_row;   // row inside the displayed area
	logic        vs_start;
	sync_state_e state;
	logic [7:0]  seq_cnt;    // lines since vsync start
	logic [7:0]  seq_next;

	assign last_line = line >= regs.ctv;
	assign last_row  = row >= regs.vt;
	assign adj_done  = ({1'b0, adj_cnt} + 6'd1) >= {1'b0, regs.va};
	assign frame_end = in_adj ? adj_done : (last_line && last_row && regs.va == 5'd0);
	assign disp_row  = !in_adj && row < regs.vd;
	assign vs_start  = levt.hSyncStart && !in_adj && line == 5'd0 && row == regs.vp - 8'd1;
	assign seq_next  = seq_cnt + 8'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			line    <= 5'd0;
			row     <= 8'd0;
			adj_cnt <= 5'd0;
			in_adj  <= 1'b0;
		end else if (enable && levt.lineEnd) begin
			if (frame_end) begin  // back to row 0 line 0
				line    <= 5'd0;
				row     <= 8'd0;
				adj_cnt <= 5'd0;
				in_adj  <= 1'b0;
			end else if (in_adj) begin
				adj_cnt <= adj_cnt + 5'd1;
			end else if (last_line) begin
				line <= 5'd0;
				if (last_row) begin
					in_adj  <= 1'b1;  // va lines still to go
					adj_cnt <= 5'd0;
				end else begin
					row <= row + 8'd1;
				end
			end else begin
				line <= line + 5'd1;
			end
		end
	end

	// flags and strobes sampled off the counters at line start
	always_ff @(posedge clk) begin
		if (reset) begin
			vVisible    <= 1'b0;
			fetchFrame  <= 1'b0;
			fetchRow    <= 1'b0;
			fetchLine   <= 1'b0;
			updateBlink <= 1'b0;
		end else begin
			if (levt.lineStart)
				vVisible <= disp_row;
			fetchFrame  <= levt.lineStart && !in_adj && row == 8'd0 && line == 5'd0;
			fetchRow    <= levt.lineStart && disp_row && line == 5'd0;
			fetchLine   <= levt.lineStart && disp_row;
			updateBlink <= enable && levt.lineEnd && frame_end;
		end
	end

	// vsync and vblank both timed in hsync starts
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= st_idle;
			seq_cnt <= 8'd0;
			vsync   <= 1'b0;
			vblank  <= 1'b0;
		end else if (enable) begin
			if (vs_start) begin
				state   <= st_sync;
				seq_cnt <= 8'd0;
				vsync   <= regs.vw != 4'd0;
				if (vb_on == 8'd0)
					vblank <= 1'b1;
			end else if (state != st_idle && levt.hSyncStart) begin
				seq_cnt <= seq_next;
				if (seq_next == vb_on)
					vblank <= 1'b1;
				if (seq_next == vb_off)
					vblank <= 1'b0;
				case (state)
					st_sync: begin
						if (seq_next >= {4'd0, regs.vw}) begin  // vw lines elapsed
							vsync <= 1'b0;
							state <= (seq_next >= vb_off) ? st_idle : st_blank;
						end
					end
					st_blank: begin
						if (seq_next >= vb_off)
							state <= st_idle;
					end
					default: ;
				endcase
			end
		end
	end

	// a frame end wraps the counters, so the next line start is the frame fetch
	a_frame_wrap: assert property (@(posedge clk) disable iff (reset)
		updateBlink && enable |=> fetchFrame)
		else $error("frame end not followed by fetchFrame");

endmodule

// ==== src/vdc_timing_pkg.sv ====
// ------------------------------------------------
// timing side types
// column events, line events, video output bundle
// sync/blank sequencer states
// ------------------------------------------------

package vdc_timing_pkg;

	typedef struct packed {
		logic       newCol;  // first pixel of a column
		logic       endCol;  // last pixel of a column
		logic [7:0] col;     // current column
	} col_evt_t;

	typedef struct packed {
		logic lineStart;   // first pixel of column 0
		logic hSyncStart;  // last pixel before hsync
		logic lineEnd;     // last pixel of column ht
	} line_evt_t;

	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       hblank;
		logic       vblank;
		logic       hVisible;
		logic       vVisible;
		logic       fetchFrame;
		logic       fetchRow;
		logic       fetchLine;
		logic [1:0] blink;       // [0] 16 frame toggle, [1] 15 frame toggle
	} video_t;

	typedef enum logic [1:0] {
		st_idle,   // waiting for sync start
		st_sync,   // sync pulse running
		st_blank   // sync done, blank window still open
	} sync_state_e;

endpackage

// ==== src/vdc_top.sv ====
// ------------------------------------------------
// VDC display timing top level
// APB register file feeding the timing core
// ------------------------------------------------

module vdc_top (
	input  logic                   clk,
	input  logic                   reset,
	input  vdc_reg_pkg::apb_req_t  apb_req,
	output vdc_reg_pkg::apb_rsp_t  apb_rsp,
	output vdc_timing_pkg::video_t video
);
	import vdc_reg_pkg::*;

	vdc_regs_t regs;  // live timing registers

	vdc_regfile regfile (
		.clk    (clk),
		.reset  (reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.regs   (regs)
	);

	vdc_signals signals (
		.clk  (clk),
		.reset(reset),
		.regs (regs),
		.video(video)
	);

endmodule

// ==== tb/tb_vdc.sv ====
// ------------------------------------------------
// testbench for the VDC display timing top level
// APB setup and readback, hsync/vsync period and width,
// hVisible length, hblank delay, blink phases,
// reset and disable
// tests come from tb/vdc_input.txt
// ------------------------------------------------

`include "vdc_config.svh"

module tb_vdc;
	timeunit 1ns;
	timeprecision 100ps;
	import vdc_reg_pkg::*;
	import vdc_timing_pkg::*;

	typedef struct {
		string name;
		int    ht, hd, hp, hw, vw, vt, va, vd, vp, ctv, cth, blink;
		int    hper, hwid, vper, vwid, hvis;  // expected measurements
	} test_t;

	logic       clk;
	logic       reset;
	apb_req_t   apb_req;
	apb_rsp_t   apb_rsp;
	video_t     video;
	test_t      tests[$];
	int         cycles;       // clock count for timestamps and watchdog
	int         limit;        // 0 until the test list is known
	int         test_err;
	int         n_pass;
	int         n_fail;
	int         frame_cnt;    // fetchFrame pulses since reset
	int         b0_toggles;
	int         b1_toggles;
	logic       blink_bad;    // a blink bit flipped on the wrong frame
	logic [1:0] blink_prev;

	vdc_top dut_i (
		.clk    (clk),
		.reset  (reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.video  (video)
	);

	always #20 clk = ~clk;  // 40 ns period

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// blink monitor, frames counted by fetchFrame
	always @(negedge clk) begin
		if (reset) begin
			frame_cnt  = 0;
			b0_toggles = 0;
			b1_toggles = 0;
			blink_bad  = 1'b0;
			blink_prev = 2'b00;
		end else begin
			if (video.fetchFrame)
				frame_cnt++;
			if (video.blink[0] != blink_prev[0]) begin
				b0_toggles++;
				if ((frame_cnt - 1) % 16 != 0)
					blink_bad = 1'b1;  // completed frames not a multiple of 16
			end
			if (video.blink[1] != blink_prev[1]) begin
				b1_toggles++;
				if ((frame_cnt - 1) % 15 != 0)
					blink_bad = 1'b1;
			end
			blink_prev = video.blink;
		end
	end

	task automatic check_eq(input string name, input string what, input int exp, input int act);
		if (exp != act) begin
			$display("Error %s %s: expected %0d, actual %0d", name, what, exp, act);
			test_err++;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
		repeat ($urandom % 3) @(posedge clk);  // random idle gap
		@(posedge clk);
		apb_req.psel    <= 1'b1;  // setup
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= 1'b1;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= data;
		@(posedge clk);
		apb_req.penable <= 1'b1;  // access
		@(posedge clk);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic apb_read(input string name, input logic [7:0] addr,
		output logic [7:0] data);
		repeat ($urandom % 3) @(posedge clk);
		@(posedge clk);
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= 1'b0;
		apb_req.paddr   <= addr;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		data = apb_rsp.prdata;  // valid in the access cycle
		check_eq(name, "pready", 1, int'(apb_rsp.pready));
		check_eq(name, "pslverr", 0, int'(apb_rsp.pslverr));
		@(posedge clk);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic configure(input test_t t);
		logic [7:0] addr[10];
		logic [7:0] val[10];
		logic [7:0] rd;
		addr = '{`VDC_R_HT, `VDC_R_HD, `VDC_R_HP, `VDC_R_SW, `VDC_R_VT,
			`VDC_R_VA, `VDC_R_VD, `VDC_R_VP, `VDC_R_CTV, `VDC_R_CTH};
		val[0] = 8'(t.ht);
		val[1] = 8'(t.hd);
		val[2] = 8'(t.hp);
		val[3] = {4'(t.vw), 4'(t.hw)};  // R3 packs vw over hw
		val[4] = 8'(t.vt);
		val[5] = 8'(t.va);
		val[6] = 8'(t.vd);
		val[7] = 8'(t.vp);
		val[8] = 8'(t.ctv);
		val[9] = {4'(t.cth), 4'd0};     // cth lives in the high nibble
		for (int i = 0; i < 10; i++)
			apb_write(addr[i], val[i]);
		for (int i = 0; i < 10; i++) begin
			apb_read(t.name, addr[i], rd);
			check_eq(t.name, $sformatf("readback 0x%02h", addr[i]), int'(val[i]), int'(rd));
		end
		apb_write(8'h30, 8'h5a);  // unmapped
		apb_read(t.name, 8'h30, rd);
		check_eq(t.name, "unmapped readback", 0, int'(rd));
	endtask

	function automatic logic pulse_level(input logic use_vsync);
		return use_vsync ? video.vsync : video.hsync;
	endfunction

	// clocks from the first hsync rise to the hblank rise
	task automatic measure_hblank_delay(output int delay);
		int t_rise;
		@(negedge clk);
		while (!video.hsync)
			@(negedge clk);
		t_rise = cycles;
		while (!video.hblank)
			@(negedge clk);
		delay = cycles - t_rise;
	endtask

	// one full pulse cycle of hsync or vsync, hVisible counted over it
	task automatic measure_pulse(input logic use_vsync, output int period, output int width,
		output int vis);
		int t_rise;
		int t_fall;
		vis = 0;
		@(negedge clk);
		while (pulse_level(use_vsync))
			@(negedge clk);
		while (!pulse_level(use_vsync))
			@(negedge clk);
		t_rise = cycles;
		while (pulse_level(use_vsync)) begin
			if (video.hVisible)
				vis++;
			@(negedge clk);
		end
		t_fall = cycles;
		while (!pulse_level(use_vsync)) begin
			if (video.hVisible)
				vis++;
			@(negedge clk);
		end
		period = cycles - t_rise;
		width  = t_fall - t_rise;
	endtask

	task automatic run_test(input test_t t);
		int         period;
		int         width;
		int         vis;
		int         delay;
		logic       h0;
		logic       v0;
		logic [7:0] rd;
		test_err = 0;
		@(posedge clk);
		reset <= 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (video != '0) begin
			$display("Error %s outputs after reset: expected 0, actual %0h", t.name, video);
			test_err++;
		end
		configure(t);
		apb_write(`VDC_R_CTRL, 8'h01);
		measure_hblank_delay(delay);  // hblank only rises once on short lines
		check_eq(t.name, "hblank delay", `VDC_HB_FRONT_PORCH * (t.cth + 1), delay);
		apb_read(t.name, `VDC_R_CTRL, rd);
		check_eq(t.name, "enable readback", 1, int'(rd));
		if (t.blink != 0) begin
			while (frame_cnt < 33)
				@(posedge clk);  // 32 complete frames
			check_eq(t.name, "blink[0] toggles", 2, b0_toggles);
			check_eq(t.name, "blink[1] toggles", 2, b1_toggles);
			if (blink_bad) begin
				$display("%s: a blink phase toggled on the wrong frame", t.name);
				test_err++;
			end
		end
		measure_pulse(1'b0, period, width, vis);
		check_eq(t.name, "hsync period", t.hper, period);
		check_eq(t.name, "hsync width", t.hwid, width);
		check_eq(t.name, "hVisible clocks", t.hvis, vis);
		measure_pulse(1'b1, period, width, vis);
		check_eq(t.name, "vsync period", t.vper, period);
		check_eq(t.name, "vsync width", t.vwid, width);
		apb_write(`VDC_R_CTRL, 8'h00);
		@(negedge clk);
		h0 = video.hsync;
		v0 = video.vsync;
		repeat (t.vper) begin
			@(negedge clk);
			if (video.hsync != h0 || video.vsync != v0) begin
				$display("%s: sync output moved while the core was disabled", t.name);
				test_err++;
				break;
			end
		end
		if (test_err == 0) begin
			$display("PASS %s", t.name);
			n_pass++;
		end else begin
			$display("FAIL %s (%0d errors)", t.name, test_err);
			n_fail++;
		end
	endtask

	task automatic load_tests(output logic ok);
		int    fd;
		int    n;
		int    sum;
		string line;
		test_t t;
		ok  = 1'b0;
		sum = 0;
		fd  = $fopen("tb/vdc_input.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/vdc_input.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#")
				continue;  // blank or comment
			n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				t.name, t.ht, t.hd, t.hp, t.hw, t.vw, t.vt, t.va, t.vd, t.vp, t.ctv,
				t.cth, t.blink, t.hper, t.hwid, t.vper, t.vwid, t.hvis);
			if (n != 18) begin
				$display("malformed test line in tb/vdc_input.txt: %s", line);
				$fclose(fd);
				return;
			end
			tests.push_back(t);
			sum += t.vper;
		end
		$fclose(fd);
		limit = sum * 20 + 1000;  // frame lengths times 20 plus slack
		ok = tests.size() > 0;
		if (!ok)
			$display("no tests found in tb/vdc_input.txt");
	endtask

	initial begin
		logic ok;
		clk      = 1'b0;
		reset    = 1'b1;
		apb_req  = '0;
		cycles   = 0;
		limit    = 0;
		n_pass   = 0;
		n_fail   = 0;
		test_err = 0;
		void'($urandom(32'h4123));
		load_tests(ok);
		if (!ok) begin
			$display("Simulation failed");
			$finish;
		end else begin
			foreach (tests[i])
				run_test(tests[i]);
			$display("tests run %0d, passed %0d, failed %0d", tests.size(), n_pass, n_fail);
			if (n_fail == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

// ==== tb/vdc_input.txt ====
# name ht hd hp hw vw vt va vd vp ctv cth blink_check
#   then expected: hsync_period hsync_width vsync_period vsync_width hvisible_clocks
basic   9  6  7 2 3 4 2 3 3 1 1 0 20 4 240 60 12
hp_zero 15 12 0 3 2 3 0 2 2 2 0 1 16 3 192 32 12
adjust  7  5  3 1 1 2 5 3 1 0 3 0 32 4 256 32 20
